// File: src/rv64_defines.svh
`ifndef RV64_DEFINES_SVH
`define RV64_DEFINES_SVH
`default_nettype none

// datapath and memory sizing
`define RV64_XLEN        64
`define RV64_DMEM_DEPTH  256
`define RV64_RESET_PC    64'h0000_0000_8000_0000

// execute info bus, unit field in the low bits
`define EXU_INFO_W       16
`define EXU_INFO_UNIT    2:0

// alu view of the info bus
`define EXU_INFO_ALU_ADD     3
`define EXU_INFO_ALU_SUB     4
`define EXU_INFO_ALU_SLL     5
`define EXU_INFO_ALU_SLT     6
`define EXU_INFO_ALU_SLTU    7
`define EXU_INFO_ALU_XOR     8
`define EXU_INFO_ALU_SRL     9
`define EXU_INFO_ALU_SRA     10
`define EXU_INFO_ALU_OR      11
`define EXU_INFO_ALU_AND     12
`define EXU_INFO_ALU_LUI     13
`define EXU_INFO_ALU_EBREAK  14
`define EXU_INFO_ALU_WOP     15

// branch/jump view
`define EXU_INFO_BJP_JAL     3
`define EXU_INFO_BJP_JALR    4
`define EXU_INFO_BJP_BEQ     5
`define EXU_INFO_BJP_BNE     6
`define EXU_INFO_BJP_BLT     7
`define EXU_INFO_BJP_BGE     8
`define EXU_INFO_BJP_BLTU    9
`define EXU_INFO_BJP_BGEU    10

// load/store view, size bits stay contiguous
`define EXU_INFO_LS_LOAD     3
`define EXU_INFO_LS_STORE    4
`define EXU_INFO_LS_USIGN    5
`define EXU_INFO_LS_BYTE     6
`define EXU_INFO_LS_HALF     7
`define EXU_INFO_LS_WORD     8
`define EXU_INFO_LS_DWORD    9

`default_nettype wire
`endif

// File: src/rv64_pkg.sv
`include "rv64_defines.svh"
`default_nettype none

package rv64_pkg;

  // major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_BRANCH    = 7'b1100011,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_SYSTEM    = 7'b1110011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011
  } rv_opcode_e;

  // value of the info bus unit field
  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_ALU  = 3'd1,
    UNIT_BJP  = 3'd2,
    UNIT_LS   = 3'd3
  } exu_unit_e;

  // decoder to execute unit
  typedef struct packed {
    logic [`RV64_XLEN-1:0]  op1;
    logic [`RV64_XLEN-1:0]  op2;
    // jump base and offset, store data rides in op2_jp
    logic [`RV64_XLEN-1:0]  op1_jp;
    logic [`RV64_XLEN-1:0]  op2_jp;
    logic [`EXU_INFO_W-1:0] info;
    logic [4:0]             rd_idx;
    logic                   rd_wr_en;
    logic                   invalid;
  } dec_bus_t;

  // retired instruction as seen on the commit outputs
  typedef struct packed {
    logic                  rd_wr_en;
    logic [4:0]            rd_idx;
    logic [`RV64_XLEN-1:0] rd_data;
    logic [`RV64_XLEN-1:0] next_pc;
    logic                  invalid;
    logic                  ebreak;
  } commit_t;

  // data memory request, word addressed
  typedef struct packed {
    logic [`RV64_XLEN-4:0] addr;
    logic                  wr_en;
    logic [7:0]            wmask;
    logic [`RV64_XLEN-1:0] wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: src/rv64_idu.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module rv64_idu
  import rv64_pkg::*;
(
  input  logic [31:0]           inst_i,
  input  logic [`RV64_XLEN-1:0] pc_i,
  input  logic [`RV64_XLEN-1:0] rs1_data_i,
  input  logic [`RV64_XLEN-1:0] rs2_data_i,
  output logic [4:0]            rs1_idx_o,
  output logic [4:0]            rs2_idx_o,
  output dec_bus_t              dec_o
);

  localparam int XW = `RV64_XLEN;

  rv_opcode_e    opcode;
  logic [4:0]    rd;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic [7:0]    f3;
  logic          f7_00, f7_20, sh64_00, sh64_10, alt;
  logic          is_op, is_opi, is_op32, is_opi32, is_load, is_store, is_branch;
  logic          is_lui, is_auipc, jal, jalr, ebreak;
  logic          r64_ok, i64_ok, r32_ok, i32_ok, reg_op, arith;
  logic          ld_ok, st_ok, br_ok, valid;
  logic          alu_op, bjp_op, ls_op;
  logic [XW-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic [`EXU_INFO_W-1:0] alu_info, bjp_info, ls_info;

  assign opcode    = rv_opcode_e'(inst_i[6:0]);
  assign rd        = inst_i[11:7];
  assign funct3    = inst_i[14:12];
  assign funct7    = inst_i[31:25];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // one bit per funct3 encoding
  assign f3      = 8'b1 << funct3;
  assign f7_00   = funct7 == 7'h00;
  assign f7_20   = funct7 == 7'h20;
  // 64-bit shifts carry a 6-bit shamt, so only funct6 is fixed
  assign sh64_00 = inst_i[31:26] == 6'h00;
  assign sh64_10 = inst_i[31:26] == 6'h10;
  // selects sub and sra
  assign alt     = inst_i[30];

  assign is_op     = opcode == OPC_OP;
  assign is_opi    = opcode == OPC_OP_IMM;
  assign is_op32   = opcode == OPC_OP_32;
  assign is_opi32  = opcode == OPC_OP_IMM_32;
  assign is_load   = opcode == OPC_LOAD;
  assign is_store  = opcode == OPC_STORE;
  assign is_branch = opcode == OPC_BRANCH;
  assign is_lui    = opcode == OPC_LUI;
  assign is_auipc  = opcode == OPC_AUIPC;
  assign jal       = opcode == OPC_JAL;
  assign jalr      = (opcode == OPC_JALR) & f3[0];
  assign ebreak    = (opcode == OPC_SYSTEM) & (inst_i[31:7] == 25'h0002000);

  // funct7 0x20 only exists for sub and sra
  assign r64_ok = is_op & (f7_00 | (f7_20 & (f3[0] | f3[5])));
  assign i64_ok = is_opi & (f3[1] ? sh64_00 : (f3[5] ? (sh64_00 | sh64_10) : 1'b1));
  // W forms: add/sub, sll, srl/sra only
  assign r32_ok = is_op32 & (f3[0] | f3[1] | f3[5]) & (f7_00 | (f7_20 & (f3[0] | f3[5])));
  assign i32_ok = is_opi32 & (f3[0] | (f3[1] & f7_00) | (f3[5] & (f7_00 | f7_20)));
  assign reg_op = r64_ok | r32_ok;
  assign arith  = reg_op | i64_ok | i32_ok;

  assign ld_ok  = is_load & ~f3[7];
  assign st_ok  = is_store & ~funct3[2];
  assign br_ok  = is_branch & ~(f3[2] | f3[3]);
  assign valid  = arith | ld_ok | st_ok | br_ok | is_lui | is_auipc | jal | jalr | ebreak;

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign imm = ({XW{i64_ok | i32_ok | ld_ok | jalr}} & imm_i)
             | ({XW{st_ok}}                        & imm_s)
             | ({XW{br_ok}}                        & imm_b)
             | ({XW{is_lui | is_auipc}}            & imm_u)
             | ({XW{jal}}                          & imm_j);

  // alu operands, jumps add 4 to pc for the link value
  assign dec_o.op1 = ({XW{arith | ld_ok | st_ok | br_ok}} & rs1_data_i)
                   | ({XW{is_auipc | jal | jalr}}         & pc_i);
  assign dec_o.op2 = ({XW{reg_op | br_ok}} & rs2_data_i)
                   | ({XW{jal | jalr}}     & XW'(4))
                   | ({XW{i64_ok | i32_ok | ld_ok | st_ok | is_lui | is_auipc}} & imm);

  // jump target operands, store data for stores
  assign dec_o.op1_jp = ({XW{jalr}} & rs1_data_i) | ({XW{br_ok | jal}} & pc_i);
  assign dec_o.op2_jp = ({XW{br_ok | jal | jalr}} & imm) | ({XW{st_ok}} & rs2_data_i);

  assign dec_o.rd_idx   = rd;
  assign dec_o.rd_wr_en = valid & (rd != 5'd0) & ~(st_ok | br_ok | ebreak);
  assign dec_o.invalid  = ~valid;

  assign alu_op = arith | is_lui | is_auipc | ebreak;
  assign bjp_op = br_ok | jal | jalr;
  assign ls_op  = ld_ok | st_ok;

  always_comb begin
    alu_info = '0;
    alu_info[`EXU_INFO_UNIT]       = UNIT_ALU;
    alu_info[`EXU_INFO_ALU_ADD]    = (arith & f3[0] & ~(reg_op & alt)) | is_auipc;
    alu_info[`EXU_INFO_ALU_SUB]    = reg_op & f3[0] & alt;
    alu_info[`EXU_INFO_ALU_SLL]    = arith & f3[1];
    alu_info[`EXU_INFO_ALU_SLT]    = arith & f3[2];
    alu_info[`EXU_INFO_ALU_SLTU]   = arith & f3[3];
    alu_info[`EXU_INFO_ALU_XOR]    = arith & f3[4];
    alu_info[`EXU_INFO_ALU_SRL]    = arith & f3[5] & ~alt;
    alu_info[`EXU_INFO_ALU_SRA]    = arith & f3[5] & alt;
    alu_info[`EXU_INFO_ALU_OR]     = arith & f3[6];
    alu_info[`EXU_INFO_ALU_AND]    = arith & f3[7];
    alu_info[`EXU_INFO_ALU_LUI]    = is_lui;
    alu_info[`EXU_INFO_ALU_EBREAK] = ebreak;
    alu_info[`EXU_INFO_ALU_WOP]    = r32_ok | i32_ok;
  end

  always_comb begin
    bjp_info = '0;
    bjp_info[`EXU_INFO_UNIT]     = UNIT_BJP;
    bjp_info[`EXU_INFO_BJP_JAL]  = jal;
    bjp_info[`EXU_INFO_BJP_JALR] = jalr;
    bjp_info[`EXU_INFO_BJP_BEQ]  = br_ok & f3[0];
    bjp_info[`EXU_INFO_BJP_BNE]  = br_ok & f3[1];
    bjp_info[`EXU_INFO_BJP_BLT]  = br_ok & f3[4];
    bjp_info[`EXU_INFO_BJP_BGE]  = br_ok & f3[5];
    bjp_info[`EXU_INFO_BJP_BLTU] = br_ok & f3[6];
    bjp_info[`EXU_INFO_BJP_BGEU] = br_ok & f3[7];
  end

  always_comb begin
    ls_info = '0;
    ls_info[`EXU_INFO_UNIT]     = UNIT_LS;
    ls_info[`EXU_INFO_LS_LOAD]  = ld_ok;
    ls_info[`EXU_INFO_LS_STORE] = st_ok;
    // lbu, lhu, lwu all have funct3 bit 2 set
    ls_info[`EXU_INFO_LS_USIGN] = ld_ok & funct3[2];
    ls_info[`EXU_INFO_LS_BYTE]  = f3[0] | f3[4];
    ls_info[`EXU_INFO_LS_HALF]  = f3[1] | f3[5];
    ls_info[`EXU_INFO_LS_WORD]  = f3[2] | f3[6];
    ls_info[`EXU_INFO_LS_DWORD] = f3[3];
  end

  assign dec_o.info = ({`EXU_INFO_W{alu_op}} & alu_info)
                    | ({`EXU_INFO_W{bjp_op}} & bjp_info)
                    | ({`EXU_INFO_W{ls_op}}  & ls_info);

  // a recognized instruction lands in exactly one execute unit
  always_comb begin
    if (!dec_o.invalid) begin
      assert #0 ($onehot({alu_op, bjp_op, ls_op}) &&
                 dec_o.info[`EXU_INFO_UNIT] inside {UNIT_ALU, UNIT_BJP, UNIT_LS});
    end
  end

endmodule

`default_nettype wire

// File: src/rv64_regfile.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module rv64_regfile (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [4:0]            rs1_idx_i,
  input  logic [4:0]            rs2_idx_i,
  input  logic [4:0]            rd_idx_i,
  input  logic [`RV64_XLEN-1:0] rd_data_i,
  input  logic                  rd_wr_en_i,
  output logic [`RV64_XLEN-1:0] rs1_data_o,
  output logic [`RV64_XLEN-1:0] rs2_data_o
);

  logic [`RV64_XLEN-1:0] regs_q [32];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (rd_wr_en_i) begin
      regs_q[rd_idx_i] <= rd_data_i;
    end
  end

  // x0 reads as zero whatever the array holds
  assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs_q[rs2_idx_i];

  // decoder drops rd writes to x0
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_wr_en_i |-> rd_idx_i != 5'd0);

endmodule

`default_nettype wire

// File: src/rv64_exu.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module rv64_exu
  import rv64_pkg::*;
(
  input  dec_bus_t              dec_i,
  input  logic [`RV64_XLEN-1:0] pc_i,
  input  logic [`RV64_XLEN-1:0] dmem_rdata_i,
  output dmem_req_t             dmem_req_o,
  output logic [`RV64_XLEN-1:0] wb_data_o,
  output logic                  br_taken_o,
  output logic [`RV64_XLEN-1:0] br_target_o
);

  localparam int XW = `RV64_XLEN;

  logic [`EXU_INFO_W-1:0] info;
  logic [XW-1:0] op1, op2, sum, jp_sum;
  logic          is_alu, is_bjp, is_ls, wop;
  logic          eq, lt, ltu, cond;
  logic [5:0]    shamt;
  logic [XW-1:0] srl_src, sra_src, sra_res, alu_raw, alu_res;
  logic [2:0]    off;
  logic [7:0]    size_mask;
  logic [15:0]   mask_rot;
  logic [127:0]  st_rot, ld_rot;
  logic [XW-1:0] ld_raw, ld_data;

  assign info = dec_i.info;
  assign op1  = dec_i.op1;
  assign op2  = dec_i.op2;
  // shared by alu add, load/store address and jump link
  assign sum  = op1 + op2;

  assign is_alu = info[`EXU_INFO_UNIT] == UNIT_ALU;
  assign is_bjp = info[`EXU_INFO_UNIT] == UNIT_BJP;
  assign is_ls  = info[`EXU_INFO_UNIT] == UNIT_LS;

  assign eq  = op1 == op2;
  assign lt  = $signed(op1) < $signed(op2);
  assign ltu = op1 < op2;

  // W ops shift the low word only
  assign wop     = info[`EXU_INFO_ALU_WOP];
  assign shamt   = wop ? {1'b0, op2[4:0]} : op2[5:0];
  assign srl_src = wop ? {32'b0, op1[31:0]} : op1;
  assign sra_src = wop ? {{32{op1[31]}}, op1[31:0]} : op1;
  assign sra_res = $signed(sra_src) >>> shamt;

  assign alu_raw = ({XW{info[`EXU_INFO_ALU_ADD]}}  & sum)
                 | ({XW{info[`EXU_INFO_ALU_SUB]}}  & (op1 - op2))
                 | ({XW{info[`EXU_INFO_ALU_SLL]}}  & (op1 << shamt))
                 | ({XW{info[`EXU_INFO_ALU_SLT]}}  & {{(XW-1){1'b0}}, lt})
                 | ({XW{info[`EXU_INFO_ALU_SLTU]}} & {{(XW-1){1'b0}}, ltu})
                 | ({XW{info[`EXU_INFO_ALU_XOR]}}  & (op1 ^ op2))
                 | ({XW{info[`EXU_INFO_ALU_SRL]}}  & (srl_src >> shamt))
                 | ({XW{info[`EXU_INFO_ALU_SRA]}}  & sra_res)
                 | ({XW{info[`EXU_INFO_ALU_OR]}}   & (op1 | op2))
                 | ({XW{info[`EXU_INFO_ALU_AND]}}  & (op1 & op2))
                 | ({XW{info[`EXU_INFO_ALU_LUI]}}  & op2);
  assign alu_res = wop ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign cond = (info[`EXU_INFO_BJP_BEQ]  & eq)
              | (info[`EXU_INFO_BJP_BNE]  & ~eq)
              | (info[`EXU_INFO_BJP_BLT]  & lt)
              | (info[`EXU_INFO_BJP_BGE]  & ~lt)
              | (info[`EXU_INFO_BJP_BLTU] & ltu)
              | (info[`EXU_INFO_BJP_BGEU] & ~ltu)
              | info[`EXU_INFO_BJP_JAL]
              | info[`EXU_INFO_BJP_JALR];
  assign br_taken_o = is_bjp & cond;
  assign jp_sum     = dec_i.op1_jp + dec_i.op2_jp;
  // jalr clears bit 0 of the target
  assign br_target_o = {jp_sum[XW-1:1], jp_sum[0] & ~info[`EXU_INFO_BJP_JALR]};

  // byte offset inside the word, accesses rotate within it
  assign off = sum[2:0];

  always_comb begin
    size_mask = 8'hff;
    if (info[`EXU_INFO_LS_BYTE]) size_mask = 8'h01;
    else if (info[`EXU_INFO_LS_HALF]) size_mask = 8'h03;
    else if (info[`EXU_INFO_LS_WORD]) size_mask = 8'h0f;
  end

  assign mask_rot = {size_mask, size_mask} << off;
  assign st_rot   = {dec_i.op2_jp, dec_i.op2_jp} << {off, 3'b000};
  assign ld_rot   = {dmem_rdata_i, dmem_rdata_i} >> {off, 3'b000};
  assign ld_raw   = ld_rot[63:0];

  assign dmem_req_o.addr  = sum[XW-1:3];
  assign dmem_req_o.wr_en = is_ls & info[`EXU_INFO_LS_STORE];
  assign dmem_req_o.wmask = mask_rot[15:8];
  assign dmem_req_o.wdata = st_rot[127:64];

  always_comb begin
    ld_data = ld_raw;
    if (info[`EXU_INFO_LS_BYTE]) begin
      ld_data = {{56{ld_raw[7] & ~info[`EXU_INFO_LS_USIGN]}}, ld_raw[7:0]};
    end else if (info[`EXU_INFO_LS_HALF]) begin
      ld_data = {{48{ld_raw[15] & ~info[`EXU_INFO_LS_USIGN]}}, ld_raw[15:0]};
    end else if (info[`EXU_INFO_LS_WORD]) begin
      ld_data = {{32{ld_raw[31] & ~info[`EXU_INFO_LS_USIGN]}}, ld_raw[31:0]};
    end
  end

  always_comb begin
    wb_data_o = '0;
    if (is_alu) wb_data_o = alu_res;
    else if (is_bjp) wb_data_o = sum;
    else if (is_ls && info[`EXU_INFO_LS_LOAD]) wb_data_o = ld_data;
  end

  // one access size per load/store, and the link value is pc+4
  always_comb begin
    if (is_ls) begin
      assert #0 ($onehot0(info[`EXU_INFO_LS_DWORD:`EXU_INFO_LS_BYTE]));
    end
    if (is_bjp && (info[`EXU_INFO_BJP_JAL] || info[`EXU_INFO_BJP_JALR])) begin
      assert #0 (sum == pc_i + XW'(4));
    end
  end

endmodule

`default_nettype wire

// File: src/rv64_dmem.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module rv64_dmem
  import rv64_pkg::*;
(
  input  logic                  clk_i,
  input  dmem_req_t             req_i,
  input  logic                  wr_commit_i,
  output logic [`RV64_XLEN-1:0] rdata_o
);

  localparam int AW = $clog2(`RV64_DMEM_DEPTH);

  logic [`RV64_XLEN-1:0] mem_q [`RV64_DMEM_DEPTH];
  logic [AW-1:0]         idx;

  // upper address bits fold onto the array
  assign idx = req_i.addr[AW-1:0];

  always_ff @(posedge clk_i) begin
    if (wr_commit_i && req_i.wr_en) begin
      for (int b = 0; b < 8; b++) begin
        if (req_i.wmask[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o = mem_q[idx];

endmodule

`default_nettype wire

// File: src/rv64_core.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module rv64_core
  import rv64_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [31:0]           inst_i,
  input  logic                  inst_valid_i,
  output logic [`RV64_XLEN-1:0] pc_o,
  output logic                  commit_o,
  output logic                  commit_rd_wr_en_o,
  output logic [4:0]            commit_rd_idx_o,
  output logic [`RV64_XLEN-1:0] commit_rd_data_o,
  output logic [`RV64_XLEN-1:0] commit_next_pc_o,
  output logic                  invalid_o,
  output logic                  halted_o
);

  localparam int XW = `RV64_XLEN;

  logic [XW-1:0] pc_q, next_pc;
  logic [XW-1:0] rs1_data, rs2_data, wb_data, br_target, dmem_rdata;
  logic [4:0]    rs1_idx, rs2_idx;
  logic          br_taken, accept, halted_q, commit_q;
  dec_bus_t      dec;
  dmem_req_t     dmem_req;
  commit_t       cm_d, cm_q;

  // single accept term for every state update
  assign accept  = inst_valid_i & ~halted_q;
  // an invalid instruction leaves the pc where it is
  assign next_pc = dec.invalid ? pc_q : (br_taken ? br_target : pc_q + XW'(4));

  assign cm_d.rd_wr_en = dec.rd_wr_en;
  assign cm_d.rd_idx   = dec.rd_idx;
  assign cm_d.rd_data  = wb_data;
  assign cm_d.next_pc  = next_pc;
  assign cm_d.invalid  = dec.invalid;
  assign cm_d.ebreak   = (dec.info[`EXU_INFO_UNIT] == UNIT_ALU) & dec.info[`EXU_INFO_ALU_EBREAK];

  rv64_idu u_idu (
    .inst_i     (inst_i),
    .pc_i       (pc_q),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .dec_o      (dec)
  );

  rv64_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .rd_idx_i   (dec.rd_idx),
    .rd_data_i  (wb_data),
    .rd_wr_en_i (accept & dec.rd_wr_en),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv64_exu u_exu (
    .dec_i        (dec),
    .pc_i         (pc_q),
    .dmem_rdata_i (dmem_rdata),
    .dmem_req_o   (dmem_req),
    .wb_data_o    (wb_data),
    .br_taken_o   (br_taken),
    .br_target_o  (br_target)
  );

  rv64_dmem u_dmem (
    .clk_i       (clk_i),
    .req_i       (dmem_req),
    .wr_commit_i (accept),
    .rdata_o     (dmem_rdata)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q     <= `RV64_RESET_PC;
      halted_q <= 1'b0;
      commit_q <= 1'b0;
      cm_q     <= '0;
    end else begin
      commit_q <= accept;
      if (accept) begin
        pc_q <= next_pc;
        cm_q <= cm_d;
        // ebreak stops the slice until reset
        if (cm_d.ebreak) halted_q <= 1'b1;
      end
    end
  end

  assign pc_o              = pc_q;
  assign commit_o          = commit_q;
  assign commit_rd_wr_en_o = cm_q.rd_wr_en;
  assign commit_rd_idx_o   = cm_q.rd_idx;
  assign commit_rd_data_o  = cm_q.rd_data;
  assign commit_next_pc_o  = cm_q.next_pc;
  assign invalid_o         = cm_q.invalid;
  assign halted_o          = halted_q;

  // once halted, no further commits and the pc holds
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted_q |=> !commit_q && $stable(pc_q));

endmodule

`default_nettype wire

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/tb_rv64_core.sv
`timescale 1ns/1ps
`include "rv64_defines.svh"
`default_nettype none

module tb_rv64_core
  import rv64_pkg::*;
();

  localparam int COMMIT_TIMEOUT = 20;
  localparam int RESET_TIMEOUT  = 100;

  logic        clk, rst_n, inst_valid;
  logic [31:0] inst;
  logic [63:0] pc_o, commit_rd_data_o, commit_next_pc_o;
  logic        commit_o, commit_rd_wr_en_o, invalid_o, halted_o;
  logic [4:0]  commit_rd_idx_o;

  // reference model state
  logic [63:0] shadow [32];
  logic [63:0] exp_pc;
  int          errors, timeouts, checks, seed;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv64_core UUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .inst_i            (inst),
    .inst_valid_i      (inst_valid),
    .pc_o              (pc_o),
    .commit_o          (commit_o),
    .commit_rd_wr_en_o (commit_rd_wr_en_o),
    .commit_rd_idx_o   (commit_rd_idx_o),
    .commit_rd_data_o  (commit_rd_data_o),
    .commit_next_pc_o  (commit_next_pc_o),
    .invalid_o         (invalid_o),
    .halted_o          (halted_o)
  );

  // instruction encoders
  function automatic logic [31:0] enc_r(input rv_opcode_e opc, input logic [2:0] f3,
                                        input logic [6:0] f7, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input rv_opcode_e opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input rv_opcode_e opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // arithmetic helpers for expected values
  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] sext12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic logic [63:0] sext_n(input logic [63:0] v, input int nb);
    logic signed [63:0] s;
    s = v << (64 - 8 * nb);
    s = s >>> (64 - 8 * nb);
    return s;
  endfunction

  function automatic logic [63:0] sra_d(input logic [63:0] v, input logic [5:0] sh);
    logic signed [63:0] s;
    s = v;
    s = s >>> sh;
    return s;
  endfunction

  function automatic logic [63:0] sra_w(input logic [31:0] v, input logic [4:0] sh);
    logic signed [31:0] s;
    s = v;
    s = s >>> sh;
    return sext32(s);
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
                                        input logic [63:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic chk(input string sig, input logic [63:0] got, input logic [63:0] exp,
                     input string ctx);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s = 0x%h, expected 0x%h (%s)", sig, got, exp, ctx);
    end
  endtask

  // one strobe, sampled by the DUT on the second edge
  task automatic issue(input logic [31:0] word);
    @(posedge clk);
    inst       <= word;
    inst_valid <= 1'b1;
    @(posedge clk);
    inst_valid <= 1'b0;
  endtask

  task automatic wait_commit(output logic seen);
    seen = 1'b0;
    for (int n = 0; n < COMMIT_TIMEOUT && !seen; n++) begin
      @(negedge clk);
      seen = commit_o;
    end
  endtask

  task automatic exec(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                      input logic [63:0] data, input logic [63:0] npc, input string name);
    logic seen;
    issue(word);
    wait_commit(seen);
    if (!seen) begin
      timeouts++;
      $display("no commit for %s within %0d cycles", name, COMMIT_TIMEOUT);
    end else begin
      chk("commit_rd_wr_en_o", commit_rd_wr_en_o, wr, name);
      if (wr) begin
        chk("commit_rd_idx_o", commit_rd_idx_o, rd, name);
        chk("commit_rd_data_o", commit_rd_data_o, data, name);
      end
      chk("commit_next_pc_o", commit_next_pc_o, npc, name);
      chk("invalid_o", invalid_o, 1'b0, name);
    end
    chk("pc_o", pc_o, npc, name);
    if (wr) shadow[rd] = data;
    exp_pc = npc;
  endtask

  task automatic step(input logic [31:0] word, input logic [4:0] rd, input logic [63:0] data,
                      input string name);
    exec(word, rd != 5'd0, rd, data, exp_pc + 64'd4, name);
  endtask

  // lui plus addi with the upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [11:0] lo;
    logic [19:0] hi;
    logic [63:0] up;
    lo = v[11:0];
    hi = v[31:12] + {19'b0, lo[11]};
    up = sext32({hi, 12'b0});
    step(enc_u(OPC_LUI, rd, hi), rd, up, "lui");
    step(enc_i(OPC_OP_IMM, 3'd0, rd, rd, lo), rd, up + sext12(lo), "addi");
  endtask

  task automatic test_reset();
    for (int n = 0; n < RESET_TIMEOUT && rst_n !== 1'b1; n++) @(posedge clk);
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("reset was never released");
    end
    @(negedge clk);
    chk("pc_o", pc_o, `RV64_RESET_PC, "reset");
    chk("commit_o", commit_o, 1'b0, "reset");
    chk("halted_o", halted_o, 1'b0, "reset");
    chk("invalid_o", invalid_o, 1'b0, "reset");
    exp_pc = `RV64_RESET_PC;
  endtask

  task automatic test_alu();
    logic [63:0] a, b;
    logic [11:0] im;
    logic [5:0]  sh;
    load_const(5'd1, $random(seed));
    step(enc_i(OPC_OP_IMM, 3'd1, 1, 1, 12'd29), 1, shadow[1] << 29, "slli");
    load_const(5'd3, $random(seed));
    step(enc_r(OPC_OP, 3'd4, 7'h00, 1, 1, 3), 1, shadow[1] ^ shadow[3], "xor");
    load_const(5'd2, $random(seed));
    a  = shadow[1];
    b  = shadow[2];
    im = $random(seed);
    sh = $random(seed);
    step(enc_r(OPC_OP, 3'd0, 7'h00, 4, 1, 2), 4, a + b, "add");
    step(enc_r(OPC_OP, 3'd0, 7'h20, 4, 1, 2), 4, a - b, "sub");
    step(enc_r(OPC_OP, 3'd1, 7'h00, 4, 1, 2), 4, a << b[5:0], "sll");
    step(enc_r(OPC_OP, 3'd2, 7'h00, 4, 1, 2), 4, {63'b0, $signed(a) < $signed(b)}, "slt");
    step(enc_r(OPC_OP, 3'd3, 7'h00, 4, 1, 2), 4, {63'b0, a < b}, "sltu");
    step(enc_r(OPC_OP, 3'd4, 7'h00, 4, 1, 2), 4, a ^ b, "xor");
    step(enc_r(OPC_OP, 3'd5, 7'h00, 4, 1, 2), 4, a >> b[5:0], "srl");
    step(enc_r(OPC_OP, 3'd5, 7'h20, 4, 1, 2), 4, sra_d(a, b[5:0]), "sra");
    step(enc_r(OPC_OP, 3'd6, 7'h00, 4, 1, 2), 4, a | b, "or");
    step(enc_r(OPC_OP, 3'd7, 7'h00, 4, 1, 2), 4, a & b, "and");
    step(enc_i(OPC_OP_IMM, 3'd0, 4, 1, im), 4, a + sext12(im), "addi");
    step(enc_i(OPC_OP_IMM, 3'd2, 4, 1, im), 4,
         {63'b0, $signed(a) < $signed(sext12(im))}, "slti");
    step(enc_i(OPC_OP_IMM, 3'd3, 4, 1, im), 4, {63'b0, a < sext12(im)}, "sltiu");
    step(enc_i(OPC_OP_IMM, 3'd4, 4, 1, im), 4, a ^ sext12(im), "xori");
    step(enc_i(OPC_OP_IMM, 3'd6, 4, 1, im), 4, a | sext12(im), "ori");
    step(enc_i(OPC_OP_IMM, 3'd7, 4, 1, im), 4, a & sext12(im), "andi");
    step(enc_i(OPC_OP_IMM, 3'd1, 4, 1, {6'h00, sh}), 4, a << sh, "slli");
    step(enc_i(OPC_OP_IMM, 3'd5, 4, 1, {6'h00, sh}), 4, a >> sh, "srli");
    step(enc_i(OPC_OP_IMM, 3'd5, 4, 1, {6'h10, sh}), 4, sra_d(a, sh), "srai");
    // W forms work on the low word and sign-extend
    step(enc_r(OPC_OP_32, 3'd0, 7'h00, 4, 1, 2), 4, sext32(a[31:0] + b[31:0]), "addw");
    step(enc_r(OPC_OP_32, 3'd0, 7'h20, 4, 1, 2), 4, sext32(a[31:0] - b[31:0]), "subw");
    step(enc_r(OPC_OP_32, 3'd1, 7'h00, 4, 1, 2), 4, sext32(a[31:0] << b[4:0]), "sllw");
    step(enc_r(OPC_OP_32, 3'd5, 7'h00, 4, 1, 2), 4, sext32(a[31:0] >> b[4:0]), "srlw");
    step(enc_r(OPC_OP_32, 3'd5, 7'h20, 4, 1, 2), 4, sra_w(a[31:0], b[4:0]), "sraw");
    step(enc_i(OPC_OP_IMM_32, 3'd0, 4, 1, im), 4,
         sext32(a[31:0] + {{20{im[11]}}, im}), "addiw");
    step(enc_i(OPC_OP_IMM_32, 3'd1, 4, 1, {7'h00, sh[4:0]}), 4,
         sext32(a[31:0] << sh[4:0]), "slliw");
    step(enc_i(OPC_OP_IMM_32, 3'd5, 4, 1, {7'h00, sh[4:0]}), 4,
         sext32(a[31:0] >> sh[4:0]), "srliw");
    step(enc_i(OPC_OP_IMM_32, 3'd5, 4, 1, {7'h20, sh[4:0]}), 4,
         sra_w(a[31:0], sh[4:0]), "sraiw");
    step(enc_u(OPC_AUIPC, 5, {im, 8'h5a}), 5, exp_pc + sext32({im, 8'h5a, 12'b0}), "auipc");
    // x0 as destination commits with no write
    exec(enc_r(OPC_OP, 3'd0, 7'h00, 0, 1, 2), 1'b0, 0, '0, exp_pc + 64'd4, "add x0");
  endtask

  task automatic test_mem();
    logic [63:0] d, v;
    int          nb, off;
    step(enc_i(OPC_OP_IMM, 3'd0, 10, 0, 12'h100), 10, 64'h100, "addi base");
    load_const(5'd11, $random(seed));
    step(enc_i(OPC_OP_IMM, 3'd1, 11, 11, 12'd32), 11, shadow[11] << 32, "slli");
    load_const(5'd12, $random(seed));
    step(enc_r(OPC_OP, 3'd4, 7'h00, 11, 11, 12), 11, shadow[11] ^ shadow[12], "xor");
    d = shadow[11];
    for (int sz = 0; sz < 4; sz++) begin
      nb  = 1 << sz;
      off = (sz == 3) ? 0 : nb;
      v   = (sz == 3) ? d : d & ((64'd1 << (8 * nb)) - 64'd1);
      exec(enc_s(3'd3, 10, 0, 12'd0), 1'b0, 0, '0, exp_pc + 64'd4, "sd clear");
      exec(enc_s(3'(sz), 10, 11, 12'(off)), 1'b0, 0, '0, exp_pc + 64'd4, "store");
      step(enc_i(OPC_LOAD, 3'(sz), 13, 10, 12'(off)), 13, sext_n(v, nb), "load signed");
      if (sz < 3) begin
        step(enc_i(OPC_LOAD, 3'(sz + 4), 13, 10, 12'(off)), 13, v, "load unsigned");
      end
      // rest of the word must still be clear
      step(enc_i(OPC_LOAD, 3'd3, 13, 10, 12'd0), 13, v << (8 * off), "ld word");
    end
  endtask

  task automatic test_branch();
    logic [2:0]  conds [6];
    logic [4:0]  ra [3];
    logic [4:0]  rb [3];
    logic [12:0] off;
    logic [63:0] tgt;
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra    = '{5'd1, 5'd2, 5'd2};
    rb    = '{5'd2, 5'd3, 5'd1};
    step(enc_i(OPC_OP_IMM, 3'd0, 1, 0, 12'hffb), 1, 64'hffff_ffff_ffff_fffb, "addi -5");
    step(enc_i(OPC_OP_IMM, 3'd0, 2, 0, 12'd7), 2, 64'd7, "addi 7");
    step(enc_i(OPC_OP_IMM, 3'd0, 3, 0, 12'd7), 3, 64'd7, "addi 7");
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        off = (p == 1) ? 13'h1ff4 : 13'd24;
        tgt = branch_taken(conds[c], shadow[ra[p]], shadow[rb[p]]) ?
              exp_pc + {{51{off[12]}}, off} : exp_pc + 64'd4;
        exec(enc_b(conds[c], ra[p], rb[p], off), 1'b0, 0, '0, tgt, "branch");
      end
    end
    exec(enc_j(5, 21'h100), 1'b1, 5, exp_pc + 64'd4, exp_pc + 64'h100, "jal");
    step(enc_i(OPC_OP_IMM, 3'd0, 6, 0, 12'h235), 6, 64'h235, "addi");
    exec(enc_i(OPC_JALR, 3'd0, 7, 6, 12'h010), 1'b1, 7, exp_pc + 64'd4,
         (shadow[6] + 64'h10) & ~64'd1, "jalr");
  endtask

  task automatic test_invalid();
    logic [31:0] bad [2];
    logic [63:0] old;
    logic        seen;
    // mul from the M extension, and a load with funct3 7
    bad[0] = enc_r(OPC_OP, 3'd0, 7'h01, 4, 1, 2);
    bad[1] = enc_i(OPC_LOAD, 3'd7, 4, 10, 12'd0);
    for (int k = 0; k < 2; k++) begin
      old = shadow[4];
      issue(bad[k]);
      wait_commit(seen);
      if (!seen) begin
        timeouts++;
        $display("no commit for an invalid instruction within %0d cycles", COMMIT_TIMEOUT);
      end else begin
        chk("invalid_o", invalid_o, 1'b1, "invalid");
        chk("commit_rd_wr_en_o", commit_rd_wr_en_o, 1'b0, "invalid");
        chk("commit_next_pc_o", commit_next_pc_o, exp_pc, "invalid");
      end
      chk("pc_o", pc_o, exp_pc, "invalid");
      step(enc_i(OPC_OP_IMM, 3'd0, 4, 4, 12'd0), 4, old, "addi after invalid");
    end
  endtask

  task automatic test_ebreak();
    logic seen;
    exec(32'h0010_0073, 1'b0, 0, '0, exp_pc + 64'd4, "ebreak");
    chk("halted_o", halted_o, 1'b1, "ebreak");
    issue(enc_i(OPC_OP_IMM, 3'd0, 4, 4, 12'd1));
    wait_commit(seen);
    checks++;
    assert (!seen) else begin
      errors++;
      $display("commit_o pulsed for a strobe after ebreak");
    end
    chk("pc_o", pc_o, exp_pc, "halted");
    chk("halted_o", halted_o, 1'b1, "halted");
  endtask

  initial begin
    inst       = '0;
    inst_valid = 1'b0;
    errors     = 0;
    timeouts   = 0;
    checks     = 0;
    seed       = 82873;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    test_reset();
    test_alu();
    test_mem();
    test_branch();
    test_invalid();
    test_ebreak();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv64_core.f
+incdir+src
src/rv64_pkg.sv
src/rv64_idu.sv
src/rv64_regfile.sv
src/rv64_exu.sv
src/rv64_dmem.sv
src/rv64_core.sv
sim/tb_clkgen.sv
sim/tb_rv64_core.sv
